//--- design/core_pkg.sv
package core_pkg;

  // datapath and register file geometry
  localparam int xlen   = 32;
  localparam int nreg   = 32;
  localparam int reg_aw = $clog2(nreg);

  // boot address of the first fetch
  localparam logic [xlen-1:0] reset_pc = 32'h1c00_0000;

  // 3R opcodes in bits 31..15
  localparam logic [16:0] op_add_w = 17'h00020;
  localparam logic [16:0] op_or    = 17'h0002a;

  // 2RI12 opcodes in bits 31..22
  localparam logic [9:0] op_addi_w = 10'h00a;
  localparam logic [9:0] op_ld_w   = 10'h0a2;
  localparam logic [9:0] op_st_w   = 10'h0a6;

  // 1RI20 opcode in bits 31..25
  localparam logic [6:0] op_lu12i_w = 7'h0a;

  // sequencer state codes
  localparam logic [2:0] st_fetch = 3'd0;
  localparam logic [2:0] st_fwait = 3'd1;
  localparam logic [2:0] st_exec  = 3'd2;
  localparam logic [2:0] st_mem   = 3'd3;
  localparam logic [2:0] st_mwait = 3'd4;
  localparam logic [2:0] st_wb    = 3'd5;

  // one fetched word, three field layouts
  typedef union packed {
    struct packed {
      logic [16:0] opcode;
      logic [4:0]  rk;
      logic [4:0]  rj;
      logic [4:0]  rd;
    } r3;
    struct packed {
      logic [9:0]  opcode;
      logic [11:0] imm;
      logic [4:0]  rj;
      logic [4:0]  rd;
    } ri12;
    struct packed {
      logic [6:0]  opcode;
      logic [19:0] imm;
      logic [4:0]  rd;
    } ri20;
  } inst_t;

endpackage

//--- design/axi_pkg.sv
package axi_pkg;

  // field widths
  localparam int id_w   = 4;
  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = data_w / 8;
  localparam int len_w  = 8;

  // fixed request attributes, single word beats only
  localparam logic [2:0] size_word   = 3'd2;
  localparam logic [1:0] burst_incr  = 2'd1;
  localparam logic [1:0] lock_normal = 2'd0;
  localparam logic [3:0] cache_none  = 4'd0;
  localparam logic [2:0] prot_none   = 3'd0;

  // transaction ids, instruction side vs data side
  localparam logic [id_w-1:0] id_fetch = 4'd0;
  localparam logic [id_w-1:0] id_data  = 4'd1;

  localparam logic [1:0] resp_okay = 2'd0;

endpackage

//--- design/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if import axi_pkg::*; ();

  // read address
  logic [id_w-1:0]   ar_id;
  logic [addr_w-1:0] ar_addr;
  logic [len_w-1:0]  ar_len;
  logic [2:0]        ar_size;
  logic [1:0]        ar_burst;
  logic [1:0]        ar_lock;
  logic [3:0]        ar_cache;
  logic [2:0]        ar_prot;
  logic              ar_valid;
  logic              ar_ready;
  // read data
  logic [id_w-1:0]   r_id;
  logic [data_w-1:0] r_data;
  logic [1:0]        r_resp;
  logic              r_last;
  logic              r_valid;
  logic              r_ready;
  // write address
  logic [id_w-1:0]   aw_id;
  logic [addr_w-1:0] aw_addr;
  logic [len_w-1:0]  aw_len;
  logic [2:0]        aw_size;
  logic [1:0]        aw_burst;
  logic [1:0]        aw_lock;
  logic [3:0]        aw_cache;
  logic [2:0]        aw_prot;
  logic              aw_valid;
  logic              aw_ready;
  // write data, no wid here
  logic [data_w-1:0] w_data;
  logic [strb_w-1:0] w_strb;
  logic              w_last;
  logic              w_valid;
  logic              w_ready;
  // write response
  logic [id_w-1:0]   b_id;
  logic [1:0]        b_resp;
  logic              b_valid;
  logic              b_ready;

  modport master (
    output ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_lock, ar_cache, ar_prot, ar_valid,
    input  ar_ready,
    input  r_id, r_data, r_resp, r_last, r_valid,
    output r_ready,
    output aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_lock, aw_cache, aw_prot, aw_valid,
    input  aw_ready,
    output w_data, w_strb, w_last, w_valid,
    input  w_ready,
    input  b_id, b_resp, b_valid,
    output b_ready
  );

  modport slave (
    input  ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_lock, ar_cache, ar_prot, ar_valid,
    output ar_ready,
    output r_id, r_data, r_resp, r_last, r_valid,
    input  r_ready,
    input  aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_lock, aw_cache, aw_prot, aw_valid,
    output aw_ready,
    input  w_data, w_strb, w_last, w_valid,
    output w_ready,
    output b_id, b_resp, b_valid,
    input  b_ready
  );

endinterface

//--- design/bus_master.sv
`timescale 1ns/1ps

module bus_master import axi_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  input  logic              req,
  input  logic              we,
  input  logic [addr_w-1:0] addr,
  input  logic [data_w-1:0] wdata,
  input  logic [id_w-1:0]   id,
  output logic              done,
  output logic [data_w-1:0] rdata,
  mem_bus_if.master         bus
);

  // one flag per open channel
  logic ar_valid_q;
  logic r_wait_q;
  logic aw_valid_q;
  logic w_valid_q;
  logic b_wait_q;
  // request held for the whole transaction
  logic [addr_w-1:0] addr_q;
  logic [data_w-1:0] wdata_q;
  logic [id_w-1:0]   id_q;
  // response matches the open request
  logic r_hit;
  logic b_hit;
  // address or data beat still pending after this cycle
  logic aw_left;
  logic w_left;

  assign r_hit   = r_wait_q && bus.r_valid && bus.r_last && (bus.r_id == id_q);
  assign b_hit   = b_wait_q && bus.b_valid && (bus.b_id == id_q);
  assign aw_left = aw_valid_q && !bus.aw_ready;
  assign w_left  = w_valid_q && !bus.w_ready;

  always_ff @(posedge aclk) begin
    if (req) begin
      addr_q  <= addr;
      wdata_q <= wdata;
      id_q    <= id;
    end
    if (r_hit && bus.r_resp == resp_okay) begin
      rdata <= bus.r_data;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      ar_valid_q <= 1'b0;
      r_wait_q   <= 1'b0;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
      b_wait_q   <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      // read side, ar then r
      if (req && !we) begin
        ar_valid_q <= 1'b1;
      end else if (ar_valid_q && bus.ar_ready) begin
        ar_valid_q <= 1'b0;
        r_wait_q   <= 1'b1;
      end else if (r_hit) begin
        r_wait_q <= 1'b0;
        // error response replays the read
        if (bus.r_resp == resp_okay) begin
          done <= 1'b1;
        end else begin
          ar_valid_q <= 1'b1;
        end
      end
      // write side, aw and w in parallel then b
      if (req && we) begin
        aw_valid_q <= 1'b1;
        w_valid_q  <= 1'b1;
      end else if (b_hit) begin
        b_wait_q <= 1'b0;
        if (bus.b_resp == resp_okay) begin
          done <= 1'b1;
        end else begin
          aw_valid_q <= 1'b1;
          w_valid_q  <= 1'b1;
        end
      end else begin
        aw_valid_q <= aw_left;
        w_valid_q  <= w_left;
        // last of the two handshakes opens the b wait
        if ((aw_valid_q || w_valid_q) && !aw_left && !w_left) begin
          b_wait_q <= 1'b1;
        end
      end
    end
  end

  // single beat word reads
  assign bus.ar_id    = id_q;
  assign bus.ar_addr  = addr_q;
  assign bus.ar_len   = '0;
  assign bus.ar_size  = size_word;
  assign bus.ar_burst = burst_incr;
  assign bus.ar_lock  = lock_normal;
  assign bus.ar_cache = cache_none;
  assign bus.ar_prot  = prot_none;
  assign bus.ar_valid = ar_valid_q;
  // one outstanding transaction, responses always taken
  assign bus.r_ready  = 1'b1;
  assign bus.b_ready  = 1'b1;
  // single beat full word writes
  assign bus.aw_id    = id_q;
  assign bus.aw_addr  = addr_q;
  assign bus.aw_len   = '0;
  assign bus.aw_size  = size_word;
  assign bus.aw_burst = burst_incr;
  assign bus.aw_lock  = lock_normal;
  assign bus.aw_cache = cache_none;
  assign bus.aw_prot  = prot_none;
  assign bus.aw_valid = aw_valid_q;
  assign bus.w_data   = wdata_q;
  assign bus.w_strb   = '1;
  assign bus.w_last   = 1'b1;
  assign bus.w_valid  = w_valid_q;

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file import core_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  input  logic [reg_aw-1:0] raddr1,
  input  logic [reg_aw-1:0] raddr2,
  output logic [xlen-1:0]   rdata1,
  output logic [xlen-1:0]   rdata2,
  input  logic              we,
  input  logic [reg_aw-1:0] waddr,
  input  logic [xlen-1:0]   wdata
);

  logic [xlen-1:0] regs [nreg];

  // r0 never written, so it stays at its reset value of zero
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      regs <= '{default: '0};
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous read ports
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

//--- design/core.sv
`timescale 1ns/1ps

module core import core_pkg::*, axi_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  mem_bus_if.master         mem,
  output logic [xlen-1:0]   debug_wb_pc,
  output logic [3:0]        debug_wb_rf_wen,
  output logic [reg_aw-1:0] debug_wb_rf_wnum,
  output logic [xlen-1:0]   debug_wb_rf_wdata,
  output logic [xlen-1:0]   debug_wb_inst
);

  logic [2:0]      state;
  logic [xlen-1:0] pc_q;
  inst_t           inst_q;
  // alu result or load data, written back in st_wb
  logic [xlen-1:0] res_q;

  // decoded instruction class
  logic is_add;
  logic is_or;
  logic is_addi;
  logic is_lu12i;
  logic is_ld;
  logic is_st;
  logic writes_rd;
  logic rf_we;

  logic [xlen-1:0] src1;
  logic [xlen-1:0] src2;
  logic [xlen-1:0] simm12;
  logic [xlen-1:0] alu_res;

  // bus master handshake
  logic              bm_req;
  logic              bm_we;
  logic [addr_w-1:0] bm_addr;
  logic [id_w-1:0]   bm_id;
  logic              bm_done;
  logic [data_w-1:0] bm_rdata;

  // same word checked against each field layout
  assign is_add    = inst_q.r3.opcode == op_add_w;
  assign is_or     = inst_q.r3.opcode == op_or;
  assign is_addi   = inst_q.ri12.opcode == op_addi_w;
  assign is_ld     = inst_q.ri12.opcode == op_ld_w;
  assign is_st     = inst_q.ri12.opcode == op_st_w;
  assign is_lu12i  = inst_q.ri20.opcode == op_lu12i_w;
  // anything else retires without a write
  assign writes_rd = is_add | is_or | is_addi | is_lu12i | is_ld;
  assign rf_we     = (state == st_wb) && writes_rd && (inst_q.r3.rd != '0);

  assign simm12 = {{(xlen - 12){inst_q.ri12.imm[11]}}, inst_q.ri12.imm};

  // alu
  always_comb begin
    if (is_add) begin
      alu_res = src1 + src2;
    end else if (is_or) begin
      alu_res = src1 | src2;
    end else if (is_addi) begin
      alu_res = src1 + simm12;
    end else begin
      alu_res = {inst_q.ri20.imm, 12'h000};
    end
  end

  // fetch uses the pc, ld/st use rj plus offset
  assign bm_req  = (state == st_fetch) || (state == st_mem);
  assign bm_we   = (state == st_mem) && is_st;
  assign bm_addr = (state == st_fetch) ? pc_q : src1 + simm12;
  assign bm_id   = (state == st_fetch) ? id_fetch : id_data;

  // sequencer, one instruction at a time
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_fetch;
      pc_q  <= reset_pc;
    end else begin
      case (state)
        st_fetch: state <= st_fwait;
        st_fwait: begin
          if (bm_done) begin
            state <= st_exec;
          end
        end
        st_exec:  state <= (is_ld || is_st) ? st_mem : st_wb;
        st_mem:   state <= st_mwait;
        st_mwait: begin
          if (bm_done) begin
            state <= st_wb;
          end
        end
        st_wb: begin
          pc_q  <= pc_q + 32'd4;
          state <= st_fetch;
        end
        default:  state <= st_fetch;
      endcase
    end
  end

  // instruction word and result
  always_ff @(posedge aclk) begin
    if (state == st_fwait && bm_done) begin
      inst_q <= bm_rdata;
    end
    if (state == st_exec) begin
      res_q <= alu_res;
    end else if (state == st_mwait && bm_done && is_ld) begin
      res_q <= bm_rdata;
    end
  end

  // rj on port 1, rk for 3R or rd as st.w data on port 2
  reg_file u_reg_file (
    .aclk   (aclk),
    .arst_n (arst_n),
    .raddr1 (inst_q.r3.rj),
    .raddr2 (is_st ? inst_q.ri12.rd : inst_q.r3.rk),
    .rdata1 (src1),
    .rdata2 (src2),
    .we     (rf_we),
    .waddr  (inst_q.r3.rd),
    .wdata  (res_q)
  );

  bus_master u_bus_master (
    .aclk   (aclk),
    .arst_n (arst_n),
    .req    (bm_req),
    .we     (bm_we),
    .addr   (bm_addr),
    .wdata  (src2),
    .id     (bm_id),
    .done   (bm_done),
    .rdata  (bm_rdata),
    .bus    (mem)
  );

  // writeback trace, wen only in st_wb
  assign debug_wb_pc       = pc_q;
  assign debug_wb_rf_wen   = {4{rf_we}};
  assign debug_wb_rf_wnum  = inst_q.r3.rd;
  assign debug_wb_rf_wdata = res_q;
  assign debug_wb_inst     = inst_q;

endmodule

//--- design/core_top.sv
`timescale 1ns/1ps

module core_top import axi_pkg::*, core_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  // read address
  output logic [id_w-1:0]   arid,
  output logic [addr_w-1:0] araddr,
  output logic [len_w-1:0]  arlen,
  output logic [2:0]        arsize,
  output logic [1:0]        arburst,
  output logic [1:0]        arlock,
  output logic [3:0]        arcache,
  output logic [2:0]        arprot,
  output logic              arvalid,
  input  logic              arready,
  // read data
  input  logic [id_w-1:0]   rid,
  input  logic [data_w-1:0] rdata,
  input  logic [1:0]        rresp,
  input  logic              rlast,
  input  logic              rvalid,
  output logic              rready,
  // write address
  output logic [id_w-1:0]   awid,
  output logic [addr_w-1:0] awaddr,
  output logic [len_w-1:0]  awlen,
  output logic [2:0]        awsize,
  output logic [1:0]        awburst,
  output logic [1:0]        awlock,
  output logic [3:0]        awcache,
  output logic [2:0]        awprot,
  output logic              awvalid,
  input  logic              awready,
  // write data
  output logic [id_w-1:0]   wid,
  output logic [data_w-1:0] wdata,
  output logic [strb_w-1:0] wstrb,
  output logic              wlast,
  output logic              wvalid,
  input  logic              wready,
  // write response
  input  logic [id_w-1:0]   bid,
  input  logic [1:0]        bresp,
  input  logic              bvalid,
  output logic              bready,
  // writeback trace
  output logic [xlen-1:0]   debug_wb_pc,
  output logic [3:0]        debug_wb_rf_wen,
  output logic [reg_aw-1:0] debug_wb_rf_wnum,
  output logic [xlen-1:0]   debug_wb_rf_wdata,
  output logic [xlen-1:0]   debug_wb_inst
);

  logic [1:0] rst_sync;
  logic       rst_n;

  mem_bus_if bus ();

  // async assert, release through two flops
  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end
  assign rst_n = rst_sync[1];

  // inbound channel signals
  assign bus.ar_ready = arready;
  assign bus.r_id     = rid;
  assign bus.r_data   = rdata;
  assign bus.r_resp   = rresp;
  assign bus.r_last   = rlast;
  assign bus.r_valid  = rvalid;
  assign bus.aw_ready = awready;
  assign bus.w_ready  = wready;
  assign bus.b_id     = bid;
  assign bus.b_resp   = bresp;
  assign bus.b_valid  = bvalid;

  // outbound channel signals
  assign arid    = bus.ar_id;
  assign araddr  = bus.ar_addr;
  assign arlen   = bus.ar_len;
  assign arsize  = bus.ar_size;
  assign arburst = bus.ar_burst;
  assign arlock  = bus.ar_lock;
  assign arcache = bus.ar_cache;
  assign arprot  = bus.ar_prot;
  assign arvalid = bus.ar_valid;
  assign rready  = bus.r_ready;
  assign awid    = bus.aw_id;
  assign awaddr  = bus.aw_addr;
  assign awlen   = bus.aw_len;
  assign awsize  = bus.aw_size;
  assign awburst = bus.aw_burst;
  assign awlock  = bus.aw_lock;
  assign awcache = bus.aw_cache;
  assign awprot  = bus.aw_prot;
  assign awvalid = bus.aw_valid;
  // axi3 wid follows the write address id
  assign wid     = bus.aw_id;
  assign wdata   = bus.w_data;
  assign wstrb   = bus.w_strb;
  assign wlast   = bus.w_last;
  assign wvalid  = bus.w_valid;
  assign bready  = bus.b_ready;

  core u_core (
    .aclk              (aclk),
    .arst_n            (rst_n),
    .mem               (bus),
    .debug_wb_pc       (debug_wb_pc),
    .debug_wb_rf_wen   (debug_wb_rf_wen),
    .debug_wb_rf_wnum  (debug_wb_rf_wnum),
    .debug_wb_rf_wdata (debug_wb_rf_wdata),
    .debug_wb_inst     (debug_wb_inst)
  );

endmodule

//--- bench/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem import axi_pkg::*; (
  input  logic              aclk,
  input  logic              arst_n,
  input  logic              rand_en,
  input  logic [id_w-1:0]   arid,
  input  logic [addr_w-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [id_w-1:0]   rid,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rlast,
  output logic              rvalid,
  input  logic              rready,
  input  logic [id_w-1:0]   awid,
  input  logic [addr_w-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [id_w-1:0]   bid,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready
);

  // byte address bits 11..2 select the word
  logic [31:0] mem [1024];
  logic [31:0] lfsr;
  // cycles left before each ready
  logic [1:0]  ar_cnt;
  logic [1:0]  aw_cnt;
  logic [1:0]  w_cnt;
  // write beats collected so far
  logic              aw_got;
  logic              w_got;
  logic [addr_w-1:0] aw_addr_q;
  logic [id_w-1:0]   aw_id_q;
  logic [data_w-1:0] w_data_q;
  logic [strb_w-1:0] w_strb_q;

  initial lfsr = 32'h8299ef3e;

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] step_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one lfsr step per delay bit
  function automatic logic [1:0] draw_delay();
    logic [1:0] d;
    lfsr = step_lfsr(lfsr);
    d[0] = lfsr[0];
    lfsr = step_lfsr(lfsr);
    d[1] = lfsr[0];
    return rand_en ? d : 2'd0;
  endfunction

  assign rresp = resp_okay;
  assign rlast = 1'b1;
  assign bresp = resp_okay;

  always @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rid     <= '0;
      rdata   <= '0;
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
      bid     <= '0;
      aw_got  <= 1'b0;
      w_got   <= 1'b0;
      ar_cnt  <= 2'd0;
      aw_cnt  <= 2'd0;
      w_cnt   <= 2'd0;
    end else begin
      // read address then one data beat
      arready <= 1'b0;
      if (arvalid && arready) begin
        rvalid <= 1'b1;
        rid    <= arid;
        rdata  <= mem[araddr[11:2]];
        ar_cnt <= draw_delay();
      end else if (arvalid && !rvalid) begin
        if (ar_cnt == 2'd0) begin
          arready <= 1'b1;
        end else begin
          ar_cnt <= ar_cnt - 2'd1;
        end
      end
      if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
      // aw and w accepted independently
      awready <= 1'b0;
      if (awvalid && awready) begin
        aw_got    <= 1'b1;
        aw_addr_q <= awaddr;
        aw_id_q   <= awid;
        aw_cnt    <= draw_delay();
      end else if (awvalid && !aw_got) begin
        if (aw_cnt == 2'd0) begin
          awready <= 1'b1;
        end else begin
          aw_cnt <= aw_cnt - 2'd1;
        end
      end
      wready <= 1'b0;
      if (wvalid && wready) begin
        w_got    <= 1'b1;
        w_data_q <= wdata;
        w_strb_q <= wstrb;
        w_cnt    <= draw_delay();
      end else if (wvalid && !w_got) begin
        if (w_cnt == 2'd0) begin
          wready <= 1'b1;
        end else begin
          w_cnt <= w_cnt - 2'd1;
        end
      end
      // commit and respond once both beats are in
      if (aw_got && w_got && !bvalid) begin
        for (int b = 0; b < 4; b++) begin
          if (w_strb_q[b]) begin
            mem[aw_addr_q[11:2]][8*b +: 8] = w_data_q[8*b +: 8];
          end
        end
        bvalid <= 1'b1;
        bid    <= aw_id_q;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

endmodule

//--- bench/tb_core_top.sv
`timescale 1ns/1ps

module tb_core_top import core_pkg::*, axi_pkg::*; ();

  // instructions per directed program as run in each of two rounds
  localparam int n_alu        = 7;
  localparam int n_r0         = 6;
  localparam int n_mem        = 7;
  localparam int total_insts  = 2 * (n_alu + n_r0 + n_mem) + 2;
  localparam int watch_cycles = total_insts * 40 + 200;

  logic aclk;
  logic arst_n;
  logic rand_en;

  logic [id_w-1:0]   arid;
  logic [addr_w-1:0] araddr;
  logic [len_w-1:0]  arlen;
  logic [2:0]        arsize;
  logic [1:0]        arburst;
  logic [1:0]        arlock;
  logic [3:0]        arcache;
  logic [2:0]        arprot;
  logic              arvalid;
  logic              arready;
  logic [id_w-1:0]   rid;
  logic [data_w-1:0] rdata;
  logic [1:0]        rresp;
  logic              rlast;
  logic              rvalid;
  logic              rready;
  logic [id_w-1:0]   awid;
  logic [addr_w-1:0] awaddr;
  logic [len_w-1:0]  awlen;
  logic [2:0]        awsize;
  logic [1:0]        awburst;
  logic [1:0]        awlock;
  logic [3:0]        awcache;
  logic [2:0]        awprot;
  logic              awvalid;
  logic              awready;
  logic [id_w-1:0]   wid;
  logic [data_w-1:0] wdata;
  logic [strb_w-1:0] wstrb;
  logic              wlast;
  logic              wvalid;
  logic              wready;
  logic [id_w-1:0]   bid;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [31:0]       debug_wb_pc;
  logic [3:0]        debug_wb_rf_wen;
  logic [4:0]        debug_wb_rf_wnum;
  logic [31:0]       debug_wb_rf_wdata;
  logic [31:0]       debug_wb_inst;

  // reference register file and data memory
  logic [31:0] model_rf [32];
  logic [31:0] model_data [logic [31:0]];
  logic [9:0]  wptr;
  // expected retirements and bus traffic
  logic [31:0] e_pc[$];
  logic [31:0] e_inst[$];
  logic        e_wen[$];
  logic [4:0]  e_wnum[$];
  logic [31:0] e_wdata[$];
  logic [31:0] e_waddr[$];
  logic [31:0] e_wval[$];
  logic [31:0] e_raddr[$];
  // observed retirements and handshakes
  logic [31:0] r_pc[$];
  logic [31:0] r_inst[$];
  logic [3:0]  r_wen[$];
  logic [4:0]  r_wnum[$];
  logic [31:0] r_wdata[$];
  logic [31:0] ar_addr_log[$];
  logic [3:0]  ar_id_log[$];
  logic [31:0] aw_addr_log[$];
  logic [3:0]  aw_id_log[$];
  logic [31:0] w_data_log[$];
  logic [3:0]  w_strb_log[$];
  logic        w_last_log[$];
  logic [3:0]  w_id_log[$];
  // previous negedge sample
  logic        p_ok;
  logic [31:0] p_pc;
  logic [31:0] p_inst;
  logic [3:0]  p_wen;
  logic [4:0]  p_wnum;
  logic [31:0] p_wdata;
  logic        p_arv;
  logic        p_arr;
  logic [31:0] p_araddr;
  logic        p_awv;
  logic        p_awr;
  logic [31:0] p_awaddr;
  logic        p_wv;
  logic        p_wr;
  logic [31:0] p_wdata_bus;

  core_top dut (.*);

  tb_axi_mem mem_model (
    .aclk (aclk), .arst_n (arst_n), .rand_en (rand_en),
    .arid (arid), .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rid (rid), .rdata (rdata), .rresp (rresp), .rlast (rlast),
    .rvalid (rvalid), .rready (rready),
    .awid (awid), .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bid (bid), .bresp (bresp), .bvalid (bvalid), .bready (bready)
  );

  initial aclk = 1'b0;
  always #20 aclk = ~aclk;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // sampled on the falling edge between dut updates
  always @(negedge aclk) begin
    if (arst_n && p_ok) begin
      if (p_arv && !p_arr && (!arvalid || araddr != p_araddr)) begin
        fail_run("arvalid or araddr changed before arready");
      end
      if (p_awv && !p_awr && (!awvalid || awaddr != p_awaddr)) begin
        fail_run("awvalid or awaddr changed before awready");
      end
      if (p_wv && !p_wr && (!wvalid || wdata != p_wdata_bus)) begin
        fail_run("wvalid or wdata changed before wready");
      end
      // pc moves on right after the writeback cycle
      if (debug_wb_pc == p_pc + 32'd4) begin
        r_pc.push_back(p_pc);
        r_inst.push_back(p_inst);
        r_wen.push_back(p_wen);
        r_wnum.push_back(p_wnum);
        r_wdata.push_back(p_wdata);
      end
    end
    if (arvalid && arready) begin
      ar_addr_log.push_back(araddr);
      ar_id_log.push_back(arid);
      // single beat word read with incr burst
      check_eq("arlen", 32'(arlen), 32'h0);
      check_eq("arsize", 32'(arsize), 32'h2);
      check_eq("arburst", 32'(arburst), 32'h1);
      // normal unprivileged access
      check_eq("arlock", 32'(arlock), 32'h0);
      check_eq("arcache", 32'(arcache), 32'h0);
      check_eq("arprot", 32'(arprot), 32'h0);
    end
    if (awvalid && awready) begin
      aw_addr_log.push_back(awaddr);
      aw_id_log.push_back(awid);
      // single beat word write with incr burst
      check_eq("awlen", 32'(awlen), 32'h0);
      check_eq("awsize", 32'(awsize), 32'h2);
      check_eq("awburst", 32'(awburst), 32'h1);
      check_eq("awlock", 32'(awlock), 32'h0);
      check_eq("awcache", 32'(awcache), 32'h0);
      check_eq("awprot", 32'(awprot), 32'h0);
    end
    if (wvalid && wready) begin
      w_data_log.push_back(wdata);
      w_strb_log.push_back(wstrb);
      w_last_log.push_back(wlast);
      w_id_log.push_back(wid);
    end
    p_ok        = arst_n;
    p_pc        = debug_wb_pc;
    p_inst      = debug_wb_inst;
    p_wen       = debug_wb_rf_wen;
    p_wnum      = debug_wb_rf_wnum;
    p_wdata     = debug_wb_rf_wdata;
    p_arv       = arvalid;
    p_arr       = arready;
    p_araddr    = araddr;
    p_awv       = awvalid;
    p_awr       = awready;
    p_awaddr    = awaddr;
    p_wv        = wvalid;
    p_wr        = wready;
    p_wdata_bus = wdata;
  end

  function automatic logic [31:0] enc_3r(input logic [16:0] op, input logic [4:0] rk,
                                         input logic [4:0] rj, input logic [4:0] rd);
    return {op, rk, rj, rd};
  endfunction

  function automatic logic [31:0] enc_ri12(input logic [9:0] op, input logic [11:0] imm,
                                           input logic [4:0] rj, input logic [4:0] rd);
    return {op, imm, rj, rd};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  // clears memory and the reference state
  task automatic begin_prog();
    for (int i = 0; i < 1024; i++) begin
      mem_model.mem[i] = 32'h0;
    end
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = 32'h0;
    end
    model_data.delete();
    e_pc.delete();
    e_inst.delete();
    e_wen.delete();
    e_wnum.delete();
    e_wdata.delete();
    e_waddr.delete();
    e_wval.delete();
    e_raddr.delete();
    wptr = 10'd0;
  endtask

  // one program word plus its expected retirement
  task automatic put(input logic [31:0] word, input logic wen, input logic [4:0] rd,
                     input logic [31:0] val);
    mem_model.mem[wptr] = word;
    e_pc.push_back(reset_pc + {20'd0, wptr, 2'b00});
    e_inst.push_back(word);
    e_wen.push_back(wen && rd != 5'd0);
    e_wnum.push_back(rd);
    e_wdata.push_back(val);
    if (wen && rd != 5'd0) begin
      model_rf[rd] = val;
    end
    wptr = wptr + 10'd1;
  endtask

  task automatic i_lu12i(input logic [4:0] rd, input logic [19:0] imm);
    put({op_lu12i_w, imm, rd}, 1'b1, rd, {imm, 12'h000});
  endtask

  task automatic i_addi(input logic [4:0] rd, input logic [4:0] rj, input logic [11:0] imm);
    put(enc_ri12(op_addi_w, imm, rj, rd), 1'b1, rd, model_rf[rj] + sext12(imm));
  endtask

  task automatic i_add(input logic [4:0] rd, input logic [4:0] rj, input logic [4:0] rk);
    put(enc_3r(op_add_w, rk, rj, rd), 1'b1, rd, model_rf[rj] + model_rf[rk]);
  endtask

  task automatic i_or(input logic [4:0] rd, input logic [4:0] rj, input logic [4:0] rk);
    put(enc_3r(op_or, rk, rj, rd), 1'b1, rd, model_rf[rj] | model_rf[rk]);
  endtask

  task automatic i_st(input logic [4:0] rd, input logic [4:0] rj, input logic [11:0] off);
    logic [31:0] a;
    a = model_rf[rj] + sext12(off);
    model_data[a] = model_rf[rd];
    e_waddr.push_back(a);
    e_wval.push_back(model_rf[rd]);
    put(enc_ri12(op_st_w, off, rj, rd), 1'b0, rd, 32'h0);
  endtask

  task automatic i_ld(input logic [4:0] rd, input logic [4:0] rj, input logic [11:0] off);
    logic [31:0] a;
    a = model_rf[rj] + sext12(off);
    e_raddr.push_back(a);
    put(enc_ri12(op_ld_w, off, rj, rd), 1'b1, rd, model_data[a]);
  endtask

  task automatic pulse_reset();
    @(posedge aclk);
    arst_n <= 1'b0;
    repeat (4) @(posedge aclk);
    r_pc.delete();
    r_inst.delete();
    r_wen.delete();
    r_wnum.delete();
    r_wdata.delete();
    ar_addr_log.delete();
    ar_id_log.delete();
    aw_addr_log.delete();
    aw_id_log.delete();
    w_data_log.delete();
    w_strb_log.delete();
    w_last_log.delete();
    w_id_log.delete();
    arst_n <= 1'b1;
  endtask

  // runs the loaded program and checks retirements and bus traffic
  task automatic run_prog();
    int n_rd;
    pulse_reset();
    while (r_pc.size() < e_pc.size()) begin
      @(negedge aclk);
    end
    for (int i = 0; i < e_pc.size(); i++) begin
      check_eq("debug_wb_pc", r_pc[i], e_pc[i]);
      check_eq("debug_wb_inst", r_inst[i], e_inst[i]);
      check_eq("debug_wb_rf_wen", 32'(r_wen[i]), e_wen[i] ? 32'hf : 32'h0);
      if (e_wen[i]) begin
        check_eq("debug_wb_rf_wnum", 32'(r_wnum[i]), 32'(e_wnum[i]));
        check_eq("debug_wb_rf_wdata", r_wdata[i], e_wdata[i]);
      end
    end
    check_eq("write count", 32'(aw_addr_log.size()), 32'(e_waddr.size()));
    check_eq("write data beats", 32'(w_data_log.size()), 32'(e_waddr.size()));
    for (int i = 0; i < e_waddr.size(); i++) begin
      check_eq("awaddr", aw_addr_log[i], e_waddr[i]);
      check_eq("awid", 32'(aw_id_log[i]), 32'(id_data));
      check_eq("wdata", w_data_log[i], e_wval[i]);
      check_eq("wstrb", 32'(w_strb_log[i]), 32'hf);
      check_eq("wlast", 32'(w_last_log[i]), 32'h1);
      check_eq("wid", 32'(w_id_log[i]), 32'(id_data));
      check_eq("memory word", mem_model.mem[e_waddr[i][11:2]], e_wval[i]);
    end
    // data reads sit above the program area
    n_rd = 0;
    for (int i = 0; i < ar_addr_log.size(); i++) begin
      if (ar_addr_log[i] >= reset_pc + 32'h100) begin
        check_eq("araddr", ar_addr_log[i], e_raddr[n_rd]);
        check_eq("arid", 32'(ar_id_log[i]), 32'(id_data));
        n_rd++;
      end else begin
        check_eq("arid", 32'(ar_id_log[i]), 32'(id_fetch));
      end
    end
    check_eq("data read count", 32'(n_rd), 32'(e_raddr.size()));
  endtask

  task automatic test_reset();
    begin_prog();
    @(posedge aclk);
    arst_n <= 1'b0;
    @(negedge aclk);
    check_eq("arvalid", 32'(arvalid), 32'h0);
    check_eq("awvalid", 32'(awvalid), 32'h0);
    check_eq("wvalid", 32'(wvalid), 32'h0);
    check_eq("debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'h0);
    repeat (4) @(posedge aclk);
    arst_n <= 1'b1;
    @(negedge aclk);
    check_eq("rready", 32'(rready), 32'h1);
    check_eq("bready", 32'(bready), 32'h1);
    while (!arvalid) begin
      @(negedge aclk);
    end
    check_eq("araddr", araddr, reset_pc);
    check_eq("arid", 32'(arid), 32'(id_fetch));
    check_eq("arlen", 32'(arlen), 32'h0);
    check_eq("arsize", 32'(arsize), 32'h2);
  endtask

  task automatic test_alu();
    begin_prog();
    i_lu12i(5'd1, 20'h12345);
    i_addi(5'd1, 5'd1, 12'h678);
    i_addi(5'd2, 5'd0, 12'hfff);
    i_add(5'd3, 5'd1, 5'd2);
    i_or(5'd4, 5'd1, 5'd3);
    i_lu12i(5'd5, 20'h80000);
    i_addi(5'd5, 5'd5, 12'h7ff);
    run_prog();
  endtask

  // writes to r0 are dropped and r0 reads as zero
  task automatic test_r0();
    begin_prog();
    i_addi(5'd2, 5'd0, 12'h123);
    i_addi(5'd0, 5'd2, 12'h005);
    i_add(5'd3, 5'd0, 5'd2);
    i_or(5'd0, 5'd2, 5'd2);
    put(32'h0, 1'b0, 5'd0, 32'h0);
    i_add(5'd4, 5'd0, 5'd0);
    run_prog();
  endtask

  task automatic test_mem();
    begin_prog();
    i_lu12i(5'd4, 20'h1c000);
    i_addi(5'd4, 5'd4, 12'h104);
    i_lu12i(5'd2, 20'hcafe0);
    i_addi(5'd2, 5'd2, 12'h5a5);
    i_st(5'd2, 5'd4, 12'hffc);
    i_ld(5'd5, 5'd4, 12'hffc);
    i_add(5'd6, 5'd5, 5'd0);
    run_prog();
  endtask

  initial begin
    repeat (watch_cycles) @(posedge aclk);
    fail_run("watchdog expired before the tests finished");
  end

  initial begin
    arst_n  <= 1'b0;
    rand_en <= 1'b0;
    p_ok    = 1'b0;
    test_reset();
    for (int pass = 0; pass < 2; pass++) begin
      // second round with random ready delays
      rand_en <= (pass == 1);
      test_alu();
      test_r0();
      test_mem();
    end
    $display("test passed");
    $finish;
  end

endmodule

//--- core_top.f
design/core_pkg.sv
design/axi_pkg.sv
design/mem_bus_if.sv
design/bus_master.sv
design/reg_file.sv
design/core.sv
design/core_top.sv
bench/tb_axi_mem.sv
bench/tb_core_top.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing -f core_top.f --top-module tb_core_top -o tb_core_top

run: compile
	./obj_dir/tb_core_top

clean:
	rm -rf obj_dir
